// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  //////////////////////////////
  // cache geometry
  //////////////////////////////

  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned NUM_SETS  = 64;
  localparam int unsigned IDX_BITS  = 6;
  localparam int unsigned TAG_BITS  = 20;
  localparam int unsigned WORD_BITS = 64;
  localparam int unsigned NUM_BANKS = 4;
  localparam int unsigned OFF_BITS  = 5;
  localparam int unsigned LINE_BITS = NUM_BANKS * WORD_BITS;

  // bank select is the upper part of the line offset
  localparam int unsigned BANK_BITS  = 2;
  localparam int unsigned WORD_BYTES = WORD_BITS / 8;

  //////////////////////////////
  // request and response types
  //////////////////////////////

  typedef struct packed {
    logic                req;
    logic                tag_only;
    logic                prio;
    logic [IDX_BITS-1:0] idx;
    logic [OFF_BITS-1:0] off;
  } rd_port_t;

  typedef struct packed {
    logic                   vld;
    logic [NUM_WAYS-1:0]    we;
    logic [TAG_BITS-1:0]    tag;
    logic [IDX_BITS-1:0]    idx;
    logic [OFF_BITS-1:0]    off;
    logic [LINE_BITS-1:0]   data;
    logic [LINE_BITS/8-1:0] be;
    logic [NUM_WAYS-1:0]    vld_bits;
  } cl_wr_t;

  typedef struct packed {
    logic [NUM_WAYS-1:0]   we;
    logic [IDX_BITS-1:0]   idx;
    logic [OFF_BITS-1:0]   off;
    logic [WORD_BITS-1:0]  data;
    logic [WORD_BYTES-1:0] be;
  } word_wr_t;

  typedef struct packed {
    logic [NUM_WAYS-1:0]  vld_bits;
    logic [NUM_WAYS-1:0]  hit_oh;
    logic [WORD_BITS-1:0] data;
  } rd_rsp_t;

  typedef struct packed {
    logic [NUM_WAYS-1:0] req;
    logic                we;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] wtag;
    logic [NUM_WAYS-1:0] wvld;
  } tag_req_t;

  typedef struct packed {
    logic                                  req;
    logic                                  we;
    logic [IDX_BITS-1:0]                   idx;
    logic [NUM_WAYS-1:0][WORD_BYTES-1:0]   be;
    logic [NUM_WAYS-1:0][WORD_BITS-1:0]    wdata;
  } bank_req_t;

endpackage

`default_nettype wire

// ==== dcache_sram.sv ====
`default_nettype none

module dcache_sram #(
  parameter  int unsigned DataWidth = 64,
  parameter  int unsigned NumWords  = 64,
  parameter  int unsigned ClearBits = 0,
  localparam int unsigned BeWidth   = (DataWidth + 7) / 8,
  localparam int unsigned AddrWidth = $clog2(NumWords)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]   be_i,
  output logic [DataWidth-1:0] rdata_o
);

  // low field that reads as zero until the word is first written
  localparam logic [DataWidth-1:0] ClrMask = {DataWidth{1'b1}} >> (DataWidth - ClearBits);

  logic [DataWidth-1:0] mem_q [NumWords];
  logic [NumWords-1:0]  init_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 rinit_q;
  logic [DataWidth-1:0] bit_en;
  logic [DataWidth-1:0] old_word;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_bit_en
    assign bit_en[i] = be_i[i / 8];
  end

  assign old_word = init_q[addr_i] ? mem_q[addr_i] : (mem_q[addr_i] & ~ClrMask);

  // per-word written flags, cleared on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q  <= '0;
      rinit_q <= 1'b0;
    end else if (req_i) begin
      if (we_i) begin
        init_q[addr_i] <= 1'b1;
      end else begin
        rinit_q <= init_q[addr_i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= (old_word & ~bit_en) | (wdata_i & bit_en);
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rinit_q ? rdata_q : (rdata_q & ~ClrMask);

endmodule

`default_nettype wire

// ==== dcache_tag_array.sv ====
`default_nettype none

module dcache_tag_array (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  dcache_pkg::tag_req_t                                    tag_req_i,
  output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] tags_o,
  output logic [dcache_pkg::NUM_WAYS-1:0]                         vld_o
);
  import dcache_pkg::*;

  localparam int unsigned EntryBits = TAG_BITS + 1;

  logic [NUM_WAYS-1:0][EntryBits-1:0] entry_wdata;
  logic [NUM_WAYS-1:0][EntryBits-1:0] entry_rdata;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // valid bit sits in the low bit so the RAM clears it on reset
    assign entry_wdata[w] = {tag_req_i.wtag, tag_req_i.wvld[w]};

    dcache_sram #(
      .DataWidth (EntryBits),
      .NumWords  (NUM_SETS),
      .ClearBits (1)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req_i.req[w]),
      .we_i    (tag_req_i.we),
      .addr_i  (tag_req_i.idx),
      .wdata_i (entry_wdata[w]),
      .be_i    ('1),
      .rdata_o (entry_rdata[w])
    );

    assign tags_o[w] = entry_rdata[w][EntryBits-1:1];
    assign vld_o[w]  = entry_rdata[w][0];
  end

endmodule

`default_nettype wire

// ==== dcache_data_banks.sv ====
`default_nettype none

module dcache_data_banks (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  dcache_pkg::bank_req_t [dcache_pkg::NUM_BANKS-1:0] bank_reqs_i,
  output logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0]
               [dcache_pkg::WORD_BITS-1:0]       bank_rdata_o
);
  import dcache_pkg::*;

  localparam int unsigned BankBits = NUM_WAYS * WORD_BITS;
  localparam int unsigned BankBes  = NUM_WAYS * WORD_BYTES;

  // bank layout
  // bank k holds word k of the line, way 0 in the low bits
  logic [NUM_BANKS-1:0][BankBits-1:0] flat_wdata;
  logic [NUM_BANKS-1:0][BankBes-1:0]  flat_be;
  logic [NUM_BANKS-1:0][BankBits-1:0] flat_rdata;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
      assign flat_wdata[b][w*WORD_BITS +: WORD_BITS] = bank_reqs_i[b].wdata[w];
      assign flat_be[b][w*WORD_BYTES +: WORD_BYTES]  = bank_reqs_i[b].be[w];
      assign bank_rdata_o[b][w] = flat_rdata[b][w*WORD_BITS +: WORD_BITS];
    end

    dcache_sram #(
      .DataWidth (BankBits),
      .NumWords  (NUM_SETS),
      .ClearBits (0)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_reqs_i[b].req),
      .we_i    (bank_reqs_i[b].we),
      .addr_i  (bank_reqs_i[b].idx),
      .wdata_i (flat_wdata[b]),
      .be_i    (flat_be[b]),
      .rdata_o (flat_rdata[b])
    );
  end

endmodule

`default_nettype wire

// ==== dcache_mem_ctrl.sv ====
`default_nettype none

module dcache_mem_ctrl #(
  parameter  int unsigned NumPorts = 3,
  localparam int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  dcache_pkg::rd_port_t [NumPorts-1:0]               rd_ports_i,
  input  dcache_pkg::cl_wr_t                                cl_wr_i,
  input  dcache_pkg::word_wr_t                              word_wr_i,
  output logic [NumPorts-1:0]                               rd_ack_o,
  output logic                                              wr_ack_o,
  output dcache_pkg::tag_req_t                              tag_req_o,
  output dcache_pkg::bank_req_t [dcache_pkg::NUM_BANKS-1:0] bank_reqs_o,
  output logic [PortW-1:0]                                  sel_port_o,
  output logic [dcache_pkg::BANK_BITS-1:0]                  sel_bank_o,
  output logic [dcache_pkg::IDX_BITS-1:0]                   sel_idx_o,
  output logic                                              cmp_en_o
);
  import dcache_pkg::*;

  logic [NumPorts-1:0]  req_all;
  logic [NumPorts-1:0]  req_prio;
  logic [NumPorts-1:0]  req_mask;
  logic [PortW-1:0]     rr_q;
  logic [PortW-1:0]     rr_d;
  logic [PortW-1:0]     sel_d;
  logic                 found;
  logic                 rd_acked;
  logic                 rd_full;
  rd_port_t             sel_port;
  logic [BANK_BITS-1:0] rd_bank;
  logic [BANK_BITS-1:0] wr_bank;
  logic [PortW-1:0]     sel_port_q;
  logic [BANK_BITS-1:0] sel_bank_q;
  logic [IDX_BITS-1:0]  sel_idx_q;
  logic                 cmp_en_q;

  //////////////////////////////
  // read arbitration
  //////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_req
    assign req_all[p]  = rd_ports_i[p].req;
    assign req_prio[p] = rd_ports_i[p].req & rd_ports_i[p].prio;
  end

  // any high prio request hides all low prio ones
  assign req_mask = (|req_prio) ? req_prio : req_all;

  // first requester at or after the pointer, wrapping around
  always_comb begin : p_rr_pick
    int unsigned cand;
    cand  = 0;
    found = 1'b0;
    sel_d = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (32'(rr_q) + i) % NumPorts;
      if (!found && req_mask[cand]) begin
        found = 1'b1;
        sel_d = PortW'(cand);
      end
    end
  end

  assign rr_d     = PortW'((32'(sel_d) + 1) % NumPorts);
  assign rd_acked = found & ~cl_wr_i.vld;
  assign sel_port = rd_ports_i[sel_d];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_ack
    assign rd_ack_o[p] = rd_acked & (sel_d == PortW'(p));
  end

  //////////////////////////////
  // array requests
  //////////////////////////////

  assign rd_full = rd_acked & ~sel_port.tag_only;
  assign rd_bank = sel_port.off[OFF_BITS-1 -: BANK_BITS];
  assign wr_bank = word_wr_i.off[OFF_BITS-1 -: BANK_BITS];

  // word write loses only against a full read of the same bank
  assign wr_ack_o = ~cl_wr_i.vld & (|word_wr_i.we) & ~(rd_full & (rd_bank == wr_bank));

  always_comb begin : p_tag_req
    tag_req_o.req  = '0;
    tag_req_o.we   = 1'b0;
    tag_req_o.idx  = sel_port.idx;
    tag_req_o.wtag = cl_wr_i.tag;
    tag_req_o.wvld = cl_wr_i.vld_bits;
    if (cl_wr_i.vld) begin
      tag_req_o.req = cl_wr_i.we;
      tag_req_o.we  = 1'b1;
      tag_req_o.idx = cl_wr_i.idx;
    end else if (rd_acked) begin
      tag_req_o.req = '1;
    end
  end

  always_comb begin : p_bank_req
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      bank_reqs_o[b].req = 1'b0;
      bank_reqs_o[b].we  = 1'b0;
      bank_reqs_o[b].idx = word_wr_i.idx;
      for (int unsigned w = 0; w < NUM_WAYS; w++) begin
        bank_reqs_o[b].be[w]    = '0;
        bank_reqs_o[b].wdata[w] = word_wr_i.data;
      end
      if (cl_wr_i.vld) begin
        // line write owns every bank
        bank_reqs_o[b].req = 1'b1;
        bank_reqs_o[b].we  = 1'b1;
        bank_reqs_o[b].idx = cl_wr_i.idx;
        for (int unsigned w = 0; w < NUM_WAYS; w++) begin
          bank_reqs_o[b].be[w]    = cl_wr_i.we[w] ? cl_wr_i.be[b*WORD_BYTES +: WORD_BYTES] : '0;
          bank_reqs_o[b].wdata[w] = cl_wr_i.data[b*WORD_BITS +: WORD_BITS];
        end
      end else begin
        if (rd_full && rd_bank == BANK_BITS'(b)) begin
          bank_reqs_o[b].req = 1'b1;
          bank_reqs_o[b].idx = sel_port.idx;
        end
        if (wr_ack_o && wr_bank == BANK_BITS'(b)) begin
          bank_reqs_o[b].req = 1'b1;
          bank_reqs_o[b].we  = 1'b1;
          for (int unsigned w = 0; w < NUM_WAYS; w++) begin
            bank_reqs_o[b].be[w] = word_wr_i.we[w] ? word_wr_i.be : '0;
          end
        end
      end
    end
  end

  //////////////////////////////
  // lookup state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q       <= '0;
      sel_port_q <= '0;
      sel_bank_q <= '0;
      sel_idx_q  <= '0;
      cmp_en_q   <= 1'b0;
    end else begin
      if (rd_acked) begin
        rr_q <= rr_d;
      end
      sel_port_q <= sel_d;
      sel_bank_q <= rd_bank;
      sel_idx_q  <= sel_port.idx;
      cmp_en_q   <= rd_acked;
    end
  end

  assign sel_port_o = sel_port_q;
  assign sel_bank_o = sel_bank_q;
  assign sel_idx_o  = sel_idx_q;
  assign cmp_en_o   = cmp_en_q;

endmodule

`default_nettype wire

// ==== dcache_hit_select.sv ====
`default_nettype none

module dcache_hit_select #(
  parameter  int unsigned NumPorts = 3,
  localparam int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic [NumPorts-1:0][dcache_pkg::TAG_BITS-1:0]             rd_tag_i,
  input  logic [PortW-1:0]                                          sel_port_i,
  input  logic [dcache_pkg::BANK_BITS-1:0]                          sel_bank_i,
  input  logic                                                      cmp_en_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] tags_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]                           vld_i,
  input  logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0]
               [dcache_pkg::WORD_BITS-1:0]                          bank_rdata_i,
  input  dcache_pkg::cl_wr_t                                        cl_wr_i,
  output dcache_pkg::rd_rsp_t                                       rd_rsp_o
);
  import dcache_pkg::*;

  logic [TAG_BITS-1:0]                rd_tag;
  logic [NUM_WAYS-1:0]                hit_oh;
  logic [NUM_WAYS-1:0][WORD_BITS-1:0] way_words;
  logic [WORD_BITS-1:0]               hit_word;
  logic [BANK_BITS-1:0]               cl_bank;

  //////////////////////////////
  // tag compare
  //////////////////////////////

  // tag of the port arrives one cycle after its index
  assign rd_tag    = rd_tag_i[sel_port_i];
  assign way_words = bank_rdata_i[sel_bank_i];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign hit_oh[w] = cmp_en_i & vld_i[w] & (tags_i[w] == rd_tag);
  end

  //////////////////////////////
  // word select
  //////////////////////////////

  always_comb begin : p_way_mux
    hit_word = '0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      hit_word = hit_word | (way_words[w] & {WORD_BITS{hit_oh[w]}});
    end
  end

  // line write shows the written word at its own offset
  assign cl_bank = cl_wr_i.off[OFF_BITS-1 -: BANK_BITS];

  assign rd_rsp_o.vld_bits = vld_i;
  assign rd_rsp_o.hit_oh   = hit_oh;
  assign rd_rsp_o.data     = cl_wr_i.vld ? cl_wr_i.data[cl_bank*WORD_BITS +: WORD_BITS] : hit_word;

endmodule

`default_nettype wire

// ==== dcache_mem_top.sv ====
`default_nettype none

module dcache_mem_top #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  dcache_pkg::rd_port_t [NumPorts-1:0]           rd_ports_i,
  input  logic [NumPorts-1:0][dcache_pkg::TAG_BITS-1:0] rd_tag_i,
  input  dcache_pkg::cl_wr_t                            cl_wr_i,
  input  dcache_pkg::word_wr_t                          word_wr_i,
  output logic [NumPorts-1:0]                           rd_ack_o,
  output logic                                          wr_ack_o,
  output dcache_pkg::rd_rsp_t                           rd_rsp_o
);
  import dcache_pkg::*;

  localparam int unsigned PortW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  tag_req_t                                      tag_req;
  bank_req_t [NUM_BANKS-1:0]                     bank_reqs;
  logic [PortW-1:0]                              sel_port;
  logic [BANK_BITS-1:0]                          sel_bank;
  logic                                          cmp_en;
  logic [NUM_WAYS-1:0][TAG_BITS-1:0]             tags;
  logic [NUM_WAYS-1:0]                           vld;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_BITS-1:0] bank_rdata;

  //////////////////////////////
  // control
  //////////////////////////////

  // registered index only feeds debug, left open here
  dcache_mem_ctrl #(
    .NumPorts (NumPorts)
  ) i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_ports_i  (rd_ports_i),
    .cl_wr_i     (cl_wr_i),
    .word_wr_i   (word_wr_i),
    .rd_ack_o    (rd_ack_o),
    .wr_ack_o    (wr_ack_o),
    .tag_req_o   (tag_req),
    .bank_reqs_o (bank_reqs),
    .sel_port_o  (sel_port),
    .sel_bank_o  (sel_bank),
    .sel_idx_o   (),
    .cmp_en_o    (cmp_en)
  );

  //////////////////////////////
  // arrays
  //////////////////////////////

  dcache_tag_array i_tag_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tag_req_i (tag_req),
    .tags_o    (tags),
    .vld_o     (vld)
  );

  dcache_data_banks i_data_banks (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_reqs_i  (bank_reqs),
    .bank_rdata_o (bank_rdata)
  );

  //////////////////////////////
  // hit and readout
  //////////////////////////////

  dcache_hit_select #(
    .NumPorts (NumPorts)
  ) i_hit_select (
    .rd_tag_i     (rd_tag_i),
    .sel_port_i   (sel_port),
    .sel_bank_i   (sel_bank),
    .cmp_en_i     (cmp_en),
    .tags_i       (tags),
    .vld_i        (vld),
    .bank_rdata_i (bank_rdata),
    .cl_wr_i      (cl_wr_i),
    .rd_rsp_o     (rd_rsp_o)
  );

endmodule

`default_nettype wire

// ==== dcache_mem_sva.sv ====
`default_nettype none

module dcache_mem_sva #(
  parameter int unsigned NumPorts = 3
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic [NumPorts-1:0]  rd_ack_o,
  input logic                 wr_ack_o,
  input dcache_pkg::cl_wr_t   cl_wr_i,
  input dcache_pkg::word_wr_t word_wr_i,
  input dcache_pkg::rd_rsp_t  rd_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // at most one read port wins per cycle
  a_rd_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_o))
    else $error("more than one read port acknowledged");

  a_no_ack_in_line_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cl_wr_i.vld |-> (rd_ack_o == '0))
    else $error("read acknowledged during a line write");

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_rsp_o.hit_oh))
    else $error("hit in more than one way");

  a_word_wr_one_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ack_o |-> $onehot0(word_wr_i.we))
    else $error("granted word write enables several ways");

endmodule

bind dcache_mem_top dcache_mem_sva #(
  .NumPorts (NumPorts)
) i_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .rd_ack_o  (rd_ack_o),
  .wr_ack_o  (wr_ack_o),
  .cl_wr_i   (cl_wr_i),
  .word_wr_i (word_wr_i),
  .rd_rsp_o  (rd_rsp_o)
);

`default_nettype wire

// ==== tb_dcache_mem.sv ====
`default_nettype none

module tb_dcache_mem;
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  localparam int unsigned NUM_PORTS  = 3;
  localparam int          WAIT_LIMIT = 20;

  localparam logic [IDX_BITS-1:0] IDX_A = 6'd5;
  localparam logic [IDX_BITS-1:0] IDX_B = 6'd40;
  localparam logic [IDX_BITS-1:0] IDX_C = 6'd9;

  logic                               clk = 1'b0;
  logic                               rst_n;
  rd_port_t [NUM_PORTS-1:0]           rd_ports;
  logic [NUM_PORTS-1:0][TAG_BITS-1:0] rd_tag;
  cl_wr_t                             cl_wr;
  word_wr_t                           word_wr;
  logic [NUM_PORTS-1:0]               rd_ack;
  logic                               wr_ack;
  rd_rsp_t                            rd_rsp;

  int errors;
  int timeouts;

  // reference contents of the cache
  logic [WORD_BITS-1:0] ref_data [NUM_WAYS][NUM_SETS][NUM_BANKS];
  logic [TAG_BITS-1:0]  ref_tag  [NUM_WAYS][NUM_SETS];
  logic                 ref_vld  [NUM_WAYS][NUM_SETS];
  logic [TAG_BITS-1:0]  fill_tags [NUM_WAYS];

  always #4 clk = ~clk;

  dcache_mem_top #(
    .NumPorts (NUM_PORTS)
  ) dut_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .rd_ports_i (rd_ports),
    .rd_tag_i   (rd_tag),
    .cl_wr_i    (cl_wr),
    .word_wr_i  (word_wr),
    .rd_ack_o   (rd_ack),
    .wr_ack_o   (wr_ack),
    .rd_rsp_o   (rd_rsp)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fill_line(input int way, input logic [IDX_BITS-1:0] idx,
                           input logic [TAG_BITS-1:0] tag, input logic [OFF_BITS-1:0] off);
    logic [LINE_BITS-1:0] line;
    int                   bank;
    for (int b = 0; b < NUM_BANKS; b++) begin
      line[b*WORD_BITS +: WORD_BITS] = {$urandom(), $urandom()};
    end
    bank = int'(off[OFF_BITS-1 -: BANK_BITS]);
    @(posedge clk);
    cl_wr.vld      <= 1'b1;
    cl_wr.we       <= NUM_WAYS'(1 << way);
    cl_wr.tag      <= tag;
    cl_wr.idx      <= idx;
    cl_wr.off      <= off;
    cl_wr.data     <= line;
    cl_wr.be       <= '1;
    cl_wr.vld_bits <= NUM_WAYS'(1 << way);
    @(negedge clk);
    // reads stall and the written word shows up at once
    check_eq(64'(rd_ack), 64'(0), "read ack during line write");
    check_eq(rd_rsp.data, line[bank*WORD_BITS +: WORD_BITS], "line write bypass word");
    @(posedge clk);
    cl_wr.vld <= 1'b0;
    cl_wr.we  <= '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      ref_data[way][idx][b] = line[b*WORD_BITS +: WORD_BITS];
    end
    ref_tag[way][idx] = tag;
    ref_vld[way][idx] = 1'b1;
  endtask

  task automatic read_port(input int p, input logic tag_only, input logic [IDX_BITS-1:0] idx,
                           input logic [OFF_BITS-1:0] off, input logic [TAG_BITS-1:0] tag,
                           output rd_rsp_t rsp);
    int cycles;
    @(posedge clk);
    rd_ports[p].req      <= 1'b1;
    rd_ports[p].tag_only <= tag_only;
    rd_ports[p].prio     <= 1'b0;
    rd_ports[p].idx      <= idx;
    rd_ports[p].off      <= off;
    rd_tag[p]            <= tag;
    cycles = 0;
    @(negedge clk);
    while (!rd_ack[p] && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rd_ack[p]) begin
      timeouts++;
      $display("read on port %0d was never acknowledged", p);
    end
    @(posedge clk);
    rd_ports[p].req <= 1'b0;
    @(negedge clk);
    rsp = rd_rsp;
  endtask

  // expected hit, valid bits and word come from the reference model
  task automatic lookup_and_compare(input int p, input logic tag_only,
                                    input logic [IDX_BITS-1:0] idx,
                                    input logic [OFF_BITS-1:0] off,
                                    input logic [TAG_BITS-1:0] tag);
    rd_rsp_t              rsp;
    logic [NUM_WAYS-1:0]  exp_vld;
    logic [NUM_WAYS-1:0]  exp_hit;
    logic [WORD_BITS-1:0] exp_data;
    int                   bank;
    bank     = int'(off[OFF_BITS-1 -: BANK_BITS]);
    exp_vld  = '0;
    exp_hit  = '0;
    exp_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      exp_vld[w] = ref_vld[w][idx];
      if (ref_vld[w][idx] && ref_tag[w][idx] == tag) begin
        exp_hit[w] = 1'b1;
        exp_data   = ref_data[w][idx][bank];
      end
    end
    read_port(p, tag_only, idx, off, tag, rsp);
    check_eq(64'(rsp.vld_bits), 64'(exp_vld), "valid bits");
    check_eq(64'(rsp.hit_oh), 64'(exp_hit), "hit one-hot");
    if (!tag_only && exp_hit != '0) begin
      check_eq(rsp.data, exp_data, "read word");
    end
    // no read in flight one cycle later
    @(negedge clk);
    check_eq(64'(rd_rsp.hit_oh), 64'(0), "hit one-hot without a read");
  endtask

  task automatic write_word(input int way, input logic [IDX_BITS-1:0] idx,
                            input logic [OFF_BITS-1:0] off, input logic [WORD_BITS-1:0] data,
                            input logic [WORD_BYTES-1:0] be);
    int cycles;
    int bank;
    bank = int'(off[OFF_BITS-1 -: BANK_BITS]);
    @(posedge clk);
    word_wr.we   <= NUM_WAYS'(1 << way);
    word_wr.idx  <= idx;
    word_wr.off  <= off;
    word_wr.data <= data;
    word_wr.be   <= be;
    cycles = 0;
    @(negedge clk);
    while (!wr_ack && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!wr_ack) begin
      timeouts++;
      $display("word write to way %0d was never granted", way);
    end else begin
      for (int i = 0; i < WORD_BYTES; i++) begin
        if (be[i]) begin
          ref_data[way][idx][bank][i*8 +: 8] = data[i*8 +: 8];
        end
      end
    end
    @(posedge clk);
    word_wr.we <= '0;
  endtask

  // one read on port 0 and one word write to way 1 in the same cycle
  task automatic bank_collision(input int rd_bank, input logic tag_only, input int wr_bank,
                                input logic exp_grant);
    logic [WORD_BITS-1:0] wdata;
    wdata = {$urandom(), $urandom()};
    @(posedge clk);
    rd_ports[0].req      <= 1'b1;
    rd_ports[0].tag_only <= tag_only;
    rd_ports[0].prio     <= 1'b0;
    rd_ports[0].idx      <= IDX_A;
    rd_ports[0].off      <= OFF_BITS'(rd_bank * 8);
    rd_tag[0]            <= fill_tags[0];
    word_wr.we           <= 4'b0010;
    word_wr.idx          <= IDX_A;
    word_wr.off          <= OFF_BITS'(wr_bank * 8);
    word_wr.data         <= wdata;
    word_wr.be           <= '1;
    @(negedge clk);
    check_eq(64'(rd_ack[0]), 64'(1), "read ack next to word write");
    check_eq(64'(wr_ack), 64'(exp_grant), "word write grant");
    if (wr_ack) begin
      ref_data[1][IDX_A][wr_bank] = wdata;
    end
    @(posedge clk);
    rd_ports[0].req <= 1'b0;
    word_wr.we      <= '0;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic fill_and_hit();
    logic [TAG_BITS-1:0] tag_base;
    tag_base = TAG_BITS'($urandom());
    for (int w = 0; w < NUM_WAYS; w++) begin
      fill_tags[w] = TAG_BITS'(tag_base + w);
      fill_line(w, IDX_A, fill_tags[w], OFF_BITS'(w * 8));
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        lookup_and_compare(w % NUM_PORTS, 1'b0, IDX_A, OFF_BITS'(b * 8 + w), fill_tags[w]);
      end
    end
  endtask

  task automatic miss_and_tag_only();
    lookup_and_compare(0, 1'b0, IDX_A, OFF_BITS'(8), TAG_BITS'(fill_tags[0] + 4));
    lookup_and_compare(1, 1'b1, IDX_A, OFF_BITS'(16), fill_tags[2]);
    lookup_and_compare(2, 1'b0, IDX_B, OFF_BITS'(0), fill_tags[0]);
  endtask

  task automatic partial_word_write();
    write_word(2, IDX_A, OFF_BITS'(8), {$urandom(), $urandom()}, 8'b0011_1100);
    lookup_and_compare(1, 1'b0, IDX_A, OFF_BITS'(8), fill_tags[2]);
  endtask

  task automatic bank_conflicts();
    bank_collision(2, 1'b0, 2, 1'b0);
    bank_collision(2, 1'b0, 3, 1'b1);
    bank_collision(2, 1'b1, 2, 1'b1);
    lookup_and_compare(0, 1'b0, IDX_A, OFF_BITS'(16), fill_tags[1]);
    lookup_and_compare(0, 1'b0, IDX_A, OFF_BITS'(24), fill_tags[1]);
  endtask

  task automatic arbitration_and_stall();
    int since [NUM_PORTS];
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_ports[p].req      <= 1'b1;
      rd_ports[p].tag_only <= 1'b0;
      rd_ports[p].prio     <= (p == 1);
      rd_ports[p].idx      <= IDX_A;
      rd_ports[p].off      <= '0;
      rd_tag[p]            <= fill_tags[0];
      since[p] = 0;
    end
    // port 1 alone is high priority
    repeat (2 * NUM_PORTS) begin
      @(negedge clk);
      check_eq(64'(rd_ack), 64'(2), "ack under priority masking");
    end
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_ports[p].prio <= 1'b0;
    end
    repeat (4 * NUM_PORTS) begin
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (rd_ack[p]) begin
          since[p] = 0;
        end else begin
          since[p] = since[p] + 1;
        end
        check_eq(64'(since[p] < NUM_PORTS), 64'(1), "round-robin service gap");
      end
    end
    // requests stay up while the line write stalls them
    fill_line(3, IDX_C, TAG_BITS'($urandom()), OFF_BITS'(2 * 8 + 3));
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_ports[p].req <= 1'b0;
    end
    lookup_and_compare(2, 1'b0, IDX_C, OFF_BITS'(2 * 8), ref_tag[3][IDX_C]);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : p_main
    void'($urandom(32'h2e5d_b8df));
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    rd_ports = '0;
    rd_tag   = '0;
    cl_wr    = '0;
    word_wr  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        ref_vld[w][s] = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    fill_and_hit();
    miss_and_tag_only();
    partial_word_write();
    bank_conflicts();
    arbitration_and_stall();

    repeat (2) @(posedge clk);
    $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
dcache_pkg.sv
dcache_sram.sv
dcache_tag_array.sv
dcache_data_banks.sv
dcache_mem_ctrl.sv
dcache_hit_select.sv
dcache_mem_top.sv
dcache_mem_sva.sv
tb_dcache_mem.sv

// ==== Makefile ====
TOP := tb_dcache_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir obj_dir -f src.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir
